// File: Makefile
# Verilator build and run for the zports testbench

VERILATOR ?= verilator
TOP       ?= tb_zports
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Some tests failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mem_paging.sv
/*
 * pentagon-1024 paging
 * #7FFD with lock, #EFF7, video page and the 1M page number
 */
`timescale 1ns/1ps

module mem_paging
(
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zports_pkg::port_write_t wr_rec,
	output zports_pkg::zbyte_t      vpage,
	output zports_pkg::zbyte_t      p7ffd,
	output zports_pkg::zbyte_t      peff7_raw,
	output zports_pkg::zbyte_t      peff7,
	output logic [5:0]              pent1m_page,
	output logic                    pent1m_1m_on,
	output logic                    pent1m_ram0_0,
	output logic                    p7ffd_wr
);
	import zports_pkg::*;

	zbyte_t eff7_q;
	logic   block1m;   // EFF7 bit 2, 128k mode
	logic   lock_7ffd; // set once, cleared by reset

	assign block1m  = eff7_q[2];
	assign p7ffd_wr = wr_rec.p7ffd && !lock_7ffd;

	////////////////////////////////////////
	// 7FFD and video page
	////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd       <= '0;
			lock_7ffd   <= 1'b0;
			vpage       <= 8'h05;
			pent1m_page <= '0;
		end
		else if (p7ffd_wr)
		begin
			p7ffd <= wr_rec.data;
			if (wr_rec.data[5] && block1m)
				lock_7ffd <= 1'b1;
			// upper page bits only outside 128k mode
			pent1m_page <= {block1m ? 3'b000 : {wr_rec.data[5], wr_rec.data[7:6]},
				wr_rec.data[2:0]};
			vpage <= {6'b000001, wr_rec.data[3], 1'b1}; // screen 5 or 7
		end
		else if (wr_rec.xt && (wr_rec.idx == XT_VPAGE))
		begin
			vpage <= wr_rec.data;
		end
	end

	////////////////////////////////////////
	// EFF7
	////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			eff7_q <= '0;
		else if (wr_rec.eff7)
			eff7_q <= wr_rec.data;
	end

	assign peff7_raw = eff7_q;

	// 128k mode hides the 1M-only bits
	assign peff7 = block1m ? {eff7_q[7], 1'b0, eff7_q[5:4], 3'b000, eff7_q[0]} : eff7_q;

	assign pent1m_1m_on  = ~eff7_q[2];
	assign pent1m_ram0_0 = eff7_q[3]; // ram page 0 at #0000

endmodule

// File: port_decode.sv
/*
 * port decoder
 * turns a captured write into a registered record with one select per target
 */
`timescale 1ns/1ps

module port_decode
(
	input  logic                    zclk,
	input  logic                    rst_n,
	input  logic                    dos,
	input  zports_pkg::bus_cycle_t  cycle,
	output zports_pkg::port_write_t wr_rec
);
	import zports_pkg::*;

	zbyte_t loa;
	zbyte_t hoa;
	logic   hit_fe, hit_xt, hit_fd, hit_f7;
	logic   sel_fe, sel_xt, sel_7ffd, sel_eff7;
	zbyte_t idx_q;
	zbyte_t data_q;

	assign loa = cycle.addr[7:0];
	assign hoa = cycle.addr[15:8];

	////////////////////////////////////////
	// address match, write cycles only
	////////////////////////////////////////

	assign hit_fe = cycle.wr && (loa == PORT_FE);
	assign hit_xt = cycle.wr && (loa == PORT_XT);
	assign hit_fd = cycle.wr && (loa == PORT_FD) && !cycle.addr[15]; // A15 high is the AY

	// EFF7 is closed in shadow mode
	assign hit_f7 = cycle.wr && (loa == PORT_F7) && cycle.addr[8] && !cycle.addr[12] && !dos;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			sel_fe   <= 1'b0;
			sel_xt   <= 1'b0;
			sel_7ffd <= 1'b0;
			sel_eff7 <= 1'b0;
		end
		else
		begin
			sel_fe   <= hit_fe;
			sel_xt   <= hit_xt;
			sel_7ffd <= hit_fd;
			sel_eff7 <= hit_f7;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (cycle.wr)
		begin
			idx_q  <= hoa; // XT index lives in the high byte
			data_q <= cycle.data;
		end
	end

	assign wr_rec = '{
		fe:    sel_fe,
		xt:    sel_xt,
		p7ffd: sel_7ffd,
		eff7:  sel_eff7,
		idx:   idx_q,
		data:  data_q
	};

endmodule

// File: port_readback.sv
/*
 * z80 read data mux
 * keyboard and tape, config readback, porthit and bus direction
 */
`timescale 1ns/1ps

module port_readback
(
	input  zports_pkg::zaddr_t addr,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               tape_read,
	input  logic [4:0]         keys_in,
	input  zports_pkg::zbyte_t p7ffd,
	input  zports_pkg::zbyte_t peff7_raw,
	output zports_pkg::zbyte_t dout,
	output logic               porthit,
	output logic               dataout
);
	import zports_pkg::*;

	zbyte_t loa;
	zbyte_t be_mux;

	assign loa = addr[7:0];

	// #nnBE selected by A11..A8
	always_comb
	begin
		case (addr[11:8])
			4'hA:    be_mux = p7ffd;
			4'hB:    be_mux = peff7_raw; // unmasked value
			default: be_mux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (loa)
			PORT_FE: dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_BE: dout = be_mux;
			default: dout = 8'hFF; // floating bus
		endcase
	end

	////////////////////////////////////////
	// bus control
	////////////////////////////////////////

	// ports owned by this block
	assign porthit = (loa == PORT_FE) || (loa == PORT_XT) || (loa == PORT_FD) ||
		(loa == PORT_F7) || (loa == PORT_BE);

	assign dataout = porthit && !iorq_n && !rd_n; // drive the z80 bus

endmodule

// File: tb_zports.sv
/*
 * zports testbench
 * table-driven z80 i/o writes, reads and output checks
 */
`timescale 1ns/1ps

module tb_zports;
	import zports_pkg::*;

	localparam logic [1:0] OP_WR  = 2'd0;
	localparam logic [1:0] OP_RD  = 2'd1;
	localparam logic [1:0] OP_CHK = 2'd2; // look at outputs only

	// output selects for the table
	localparam logic [4:0] S_VCONF = 5'd0,  S_VPAGE = 5'd1,  S_XOFFS = 5'd2,  S_YOFFS = 5'd3;
	localparam logic [4:0] S_TSCONF = 5'd4, S_PALSEL = 5'd5, S_SYSCONF = 5'd6, S_MEMCONF = 5'd7;
	localparam logic [4:0] S_HINT = 5'd8,   S_VINT = 5'd9,   S_IM2 = 5'd10,   S_BORDER = 5'd11;
	localparam logic [4:0] S_PAGE = 5'd12,  S_PEFF7 = 5'd13, S_1MON = 5'd14,  S_RAM0 = 5'd15;
	localparam logic [4:0] S_DOUT = 5'd16,  S_MISS = 5'd17,  S_KEYS = 5'd18;

	localparam int READ_TIMEOUT = 20; // cycles

	typedef struct packed
	{
		logic [1:0]  op;
		logic        dos;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [4:0]  sel;
		logic [8:0]  exp;
	} step_t;

	logic        zclk = 1'b0;
	logic        rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	zaddr_t      addr;
	zbyte_t      din;
	logic [4:0]  keys_in;
	zbyte_t      dout, border, vconf, vpage, tsconf, sysconf, memconf, hint_beg, im2vect, peff7;
	offs_t       x_offs, y_offs, vint_beg;
	logic [3:0]  palsel;
	logic [5:0]  pent1m_page;
	logic        porthit, dataout, y_offs_wr, p7ffd_wr, pent1m_1m_on, pent1m_ram0_0;

	step_t       steps [$];
	int          errors = 0;
	int          checks = 0;
	int          y_pulses = 0;
	int          p7_pulses = 0;

	zports_top #(.HINT_RESET(8'd2)) dut_i (.*);

	always #10 zclk = ~zclk;

	always @(posedge zclk)
		if (y_offs_wr)
			y_pulses <= y_pulses + 1;

	always @(posedge zclk)
		if (p7ffd_wr)
			p7_pulses <= p7_pulses + 1;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic add_step(input logic [1:0] op, input logic d, input logic [15:0] a,
		input logic [7:0] data, input logic [4:0] sel, input logic [8:0] exp);
		steps.push_back('{op: op, dos: d, addr: a, data: data, sel: sel, exp: exp});
	endtask

	task automatic check_value(input string name, input logic [8:0] got, input logic [8:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [8:0] output_value(input logic [4:0] sel);
		case (sel)
			S_VCONF:   return {1'b0, vconf};
			S_VPAGE:   return {1'b0, vpage};
			S_XOFFS:   return x_offs;
			S_YOFFS:   return y_offs;
			S_TSCONF:  return {1'b0, tsconf};
			S_PALSEL:  return {5'b0, palsel};
			S_SYSCONF: return {1'b0, sysconf};
			S_MEMCONF: return {1'b0, memconf};
			S_HINT:    return {1'b0, hint_beg};
			S_VINT:    return vint_beg;
			S_IM2:     return {1'b0, im2vect};
			S_BORDER:  return {1'b0, border};
			S_PAGE:    return {3'b0, pent1m_page};
			S_PEFF7:   return {1'b0, peff7};
			S_1MON:    return {8'b0, pent1m_1m_on};
			S_RAM0:    return {8'b0, pent1m_ram0_0};
			default:   return 9'h1FF;
		endcase
	endfunction

	function automatic string output_name(input logic [4:0] sel);
		string names [16] = '{"vconf", "vpage", "x_offs", "y_offs", "tsconf", "palsel",
			"sysconf", "memconf", "hint_beg", "vint_beg", "im2vect", "border",
			"pent1m_page", "peff7", "pent1m_1m_on", "pent1m_ram0_0"};
		return (sel < 5'd16) ? names[sel] : "dout";
	endfunction

	// starts and ends just after a falling edge
	task automatic bus_write(input logic [15:0] a, input logic [7:0] data, input logic d);
		addr   = a;
		din    = data;
		dos    = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (4) @(negedge zclk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		dos    = 1'b0;
		repeat (2) @(negedge zclk);
	endtask

	task automatic bus_read(input logic [15:0] a, input logic want_hit, output logic [7:0] seen);
		logic found;
		found  = 1'b0;
		addr   = a;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		if (want_hit)
		begin
			for (int n = 0; n < READ_TIMEOUT; n++)
			begin
				@(posedge zclk);
				if (dataout)
				begin
					found = 1'b1;
					break;
				end
			end
			if (!found)
			begin
				errors++;
				$display("timeout: dataout never went high for port %h", a);
			end
		end
		else
		begin
			@(posedge zclk);
			if (dataout || porthit)
			begin
				errors++;
				$display("bus claimed for unmapped port %h at %0t ns", a, $time);
			end
		end
		seen = dout;
		@(negedge zclk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge zclk);
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	task automatic build_table();
		// reset values
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_VPAGE,   9'h005);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_PALSEL,  9'h00F);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_HINT,    9'h002);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_IM2,     9'h0FF);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_PEFF7,   9'h000);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_1MON,    9'h001);
		// extension registers with the index in the high byte
		add_step(OP_WR,  1'b0, 16'h00AF, 8'h5A, S_VCONF,   9'h05A);
		add_step(OP_WR,  1'b0, 16'h01AF, 8'h3C, S_VPAGE,   9'h03C);
		add_step(OP_WR,  1'b0, 16'h02AF, 8'h34, S_XOFFS,   9'h034);
		add_step(OP_WR,  1'b0, 16'h03AF, 8'hFF, S_XOFFS,   9'h134); // bit 0 only
		add_step(OP_WR,  1'b0, 16'h04AF, 8'h78, S_YOFFS,   9'h078);
		add_step(OP_WR,  1'b0, 16'h05AF, 8'h01, S_YOFFS,   9'h178);
		add_step(OP_WR,  1'b0, 16'h06AF, 8'h81, S_TSCONF,  9'h081);
		add_step(OP_WR,  1'b0, 16'h07AF, 8'hA5, S_PALSEL,  9'h005);
		add_step(OP_WR,  1'b0, 16'h20AF, 8'h11, S_SYSCONF, 9'h011);
		add_step(OP_WR,  1'b0, 16'h21AF, 8'h22, S_MEMCONF, 9'h022);
		add_step(OP_WR,  1'b0, 16'h22AF, 8'h33, S_HINT,    9'h033);
		add_step(OP_WR,  1'b0, 16'h23AF, 8'h44, S_VINT,    9'h044);
		add_step(OP_WR,  1'b0, 16'h24AF, 8'h03, S_VINT,    9'h144);
		add_step(OP_WR,  1'b0, 16'h25AF, 8'hF8, S_IM2,     9'h0F8);
		// border and keyboard
		add_step(OP_WR,  1'b0, 16'h0FAF, 8'hC7, S_BORDER,  9'h0C7);
		add_step(OP_WR,  1'b0, 16'h00FE, 8'hAD, S_BORDER,  9'h0F5);
		add_step(OP_RD,  1'b0, 16'h00FE, 8'h00, S_KEYS,    9'h000);
		// paging and lock
		add_step(OP_WR,  1'b0, 16'h7FFD, 8'h08, S_VPAGE,   9'h007);
		add_step(OP_WR,  1'b0, 16'h7FFD, 8'hC3, S_PAGE,    9'h01B);
		add_step(OP_WR,  1'b0, 16'h7FFD, 8'h21, S_PAGE,    9'h021); // no lock without block1m
		add_step(OP_WR,  1'b0, 16'hEFF7, 8'h9D, S_PEFF7,   9'h091);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_1MON,    9'h000);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_RAM0,    9'h001);
		add_step(OP_WR,  1'b0, 16'h7FFD, 8'hE2, S_PAGE,    9'h002); // locks
		add_step(OP_WR,  1'b0, 16'h7FFD, 8'h0D, S_PAGE,    9'h002);
		add_step(OP_CHK, 1'b0, 16'h0000, 8'h00, S_VPAGE,   9'h005);
		// readback
		add_step(OP_RD,  1'b0, 16'h0ABE, 8'h00, S_DOUT,    9'h0E2);
		add_step(OP_RD,  1'b0, 16'h0BBE, 8'h00, S_DOUT,    9'h09D);
		add_step(OP_RD,  1'b0, 16'h00BE, 8'h00, S_DOUT,    9'h0FF);
		add_step(OP_RD,  1'b0, 16'h1234, 8'h00, S_MISS,    9'h0FF);
		// EFF7 closed in shadow mode
		add_step(OP_WR,  1'b1, 16'hEFF7, 8'h00, S_PEFF7,   9'h091);
		add_step(OP_RD,  1'b0, 16'h0BBE, 8'h00, S_DOUT,    9'h09D);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		logic [7:0] seen;
		logic [8:0] exp;
		int         y_before;
		logic       y_hit;
		int         p7_before;
		logic       p7_hit;
		logic       locked;   // 7FFD lock as the bus writes imply
		logic       block_1m; // EFF7 bit 2 as last written

		void'($urandom(32'hd530));
		rst_n     = 1'b0;
		addr      = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		tape_read = 1'b0;
		keys_in   = 5'h1F;
		locked    = 1'b0;
		block_1m  = 1'b0;
		build_table();

		repeat (2) @(posedge zclk);
		@(negedge zclk);
		rst_n = 1'b1;
		@(negedge zclk);

		foreach (steps[i])
		begin
			case (steps[i].op)
				OP_WR:
				begin
					y_before = y_pulses;
					y_hit = (steps[i].addr[7:0] == 8'hAF) &&
						((steps[i].addr[15:8] == 8'h04) || (steps[i].addr[15:8] == 8'h05));
					p7_before = p7_pulses;
					p7_hit = (steps[i].addr[7:0] == 8'hFD) && !steps[i].addr[15] && !locked;
					bus_write(steps[i].addr, steps[i].data, steps[i].dos);
					check_value(output_name(steps[i].sel), output_value(steps[i].sel),
						steps[i].exp);
					check_value("y_offs_wr pulses", 9'(y_pulses - y_before), {8'b0, y_hit});
					check_value("p7ffd_wr pulses", 9'(p7_pulses - p7_before), {8'b0, p7_hit});
					if (p7_hit && steps[i].data[5] && block_1m)
						locked = 1'b1;
					if ((steps[i].addr[7:0] == 8'hF7) && steps[i].addr[8] &&
						!steps[i].addr[12] && !steps[i].dos)
						block_1m = steps[i].data[2];
				end
				OP_RD:
				begin
					exp = steps[i].exp;
					if (steps[i].sel == S_KEYS)
					begin
						keys_in   = 5'($urandom);
						tape_read = 1'($urandom);
						exp = {2'b01, tape_read, 1'b0, keys_in}; // 1, tape, 0, keys
					end
					bus_read(steps[i].addr, steps[i].sel != S_MISS, seen);
					check_value("dout", {1'b0, seen}, exp);
				end
				default:
					check_value(output_name(steps[i].sel), output_value(steps[i].sel),
						steps[i].exp);
			endcase
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// whole-run limit
	initial
	begin
		#100_000;
		$display("run did not finish within its time limit");
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: vlog.f
zports_pkg.sv
zbus_strobe.sv
port_decode.sv
xt_regs.sv
mem_paging.sv
port_readback.sv
zports_top.sv
zports_asserts.sv
tb_zports.sv

// File: xt_regs.sv
/*
 * #nnAF extension register file and border
 * video, scroll, palette, system config and interrupt positions
 */
`timescale 1ns/1ps

module xt_regs
#(
	parameter zports_pkg::zbyte_t HINT_RESET = 8'd2 // pentagon line int
)
(
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zports_pkg::port_write_t wr_rec,
	output zports_pkg::zbyte_t      border,
	output zports_pkg::zbyte_t      vconf,
	output zports_pkg::zbyte_t      tsconf,
	output zports_pkg::zbyte_t      sysconf,
	output zports_pkg::zbyte_t      memconf,
	output zports_pkg::zbyte_t      hint_beg,
	output zports_pkg::zbyte_t      im2vect,
	output logic [3:0]              palsel,
	output zports_pkg::offs_t       x_offs,
	output zports_pkg::offs_t       y_offs,
	output zports_pkg::offs_t       vint_beg,
	output logic                    y_offs_wr
);
	import zports_pkg::*;

	// either half of the Y offset, for the video line counter
	assign y_offs_wr = wr_rec.xt && ((wr_rec.idx == XT_YOFFSL) || (wr_rec.idx == XT_YOFFSH));

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf    <= '0;
			x_offs   <= '0;
			y_offs   <= '0;
			tsconf   <= '0;
			palsel   <= 4'hF;
			sysconf  <= '0;
			memconf  <= '0;
			hint_beg <= HINT_RESET;
			vint_beg <= '0;
			im2vect  <= 8'hFF; // vector bus idles high
		end
		else if (wr_rec.xt)
		begin
			case (wr_rec.idx)
				XT_VCONF:   vconf          <= wr_rec.data;
				XT_XOFFSL:  x_offs[7:0]    <= wr_rec.data;
				XT_XOFFSH:  x_offs[8]      <= wr_rec.data[0];
				XT_YOFFSL:  y_offs[7:0]    <= wr_rec.data;
				XT_YOFFSH:  y_offs[8]      <= wr_rec.data[0];
				XT_TSCONF:  tsconf         <= wr_rec.data;
				XT_PALSEL:  palsel         <= wr_rec.data[3:0];
				XT_SYSCONF: sysconf        <= wr_rec.data;
				XT_MEMCONF: memconf        <= wr_rec.data;
				XT_HSINT:   hint_beg       <= wr_rec.data;
				XT_VSINTL:  vint_beg[7:0]  <= wr_rec.data;
				XT_VSINTH:  vint_beg[8]    <= wr_rec.data[0];
				XT_IM2VECT: im2vect        <= wr_rec.data;
				default:    ; // other indices belong to dropped blocks
			endcase
		end
	end

	////////////////////////////////////////
	// border
	////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			border <= '0;
		else if (wr_rec.fe)
			border <= {5'b11110, wr_rec.data[2:0]}; // spectrum colours at the top of the palette
		else if (wr_rec.xt && (wr_rec.idx == XT_BORDER))
			border <= wr_rec.data; // full 256-colour index
	end

endmodule

// File: zbus_strobe.sv
/*
 * z80 i/o strobe stage
 * one-cycle write and read strobes with address and data captured
 */
`timescale 1ns/1ps

module zbus_strobe
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  zports_pkg::zaddr_t     addr,
	input  zports_pkg::zbyte_t     din,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	output zports_pkg::bus_cycle_t cycle
);
	import zports_pkg::*;

	logic   iowr, iord;
	logic   iowr_prev, iord_prev; // levels seen on the previous edge
	logic   wr_stb, rd_stb;
	zaddr_t addr_q;
	zbyte_t data_q;

	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_prev <= 1'b0;
			iord_prev <= 1'b0;
			wr_stb    <= 1'b0;
			rd_stb    <= 1'b0;
		end
		else
		begin
			iowr_prev <= iowr;
			iord_prev <= iord;
			wr_stb    <= iowr & ~iowr_prev; // first edge of the write only
			rd_stb    <= iord & ~iord_prev;
		end
	end

	// payload held until the next cycle starts
	always_ff @(posedge zclk)
	begin
		if ((iowr & ~iowr_prev) | (iord & ~iord_prev))
		begin
			addr_q <= addr;
			data_q <= din;
		end
	end

	assign cycle = '{wr: wr_stb, rd: rd_stb, addr: addr_q, data: data_q};

endmodule

// File: zports_asserts.sv
/*
 * zports bus protocol assertions
 * strobe width, one-hot selects and bus direction
 */
`timescale 1ns/1ps

module zports_asserts
(
	input logic                    zclk,
	input logic                    rst_n,
	input zports_pkg::bus_cycle_t  cycle,
	input zports_pkg::port_write_t wr_rec,
	input logic                    porthit,
	input logic                    dataout
);

	wr_strobe_one_cycle: assert property (@(posedge zclk) disable iff (!rst_n)
		cycle.wr |=> !cycle.wr)
		else $error("write strobe longer than one cycle");

	rd_strobe_one_cycle: assert property (@(posedge zclk) disable iff (!rst_n)
		cycle.rd |=> !cycle.rd)
		else $error("read strobe longer than one cycle");

	// decoded targets are exclusive
	one_select: assert property (@(posedge zclk) disable iff (!rst_n)
		$onehot0({wr_rec.fe, wr_rec.xt, wr_rec.p7ffd, wr_rec.eff7}))
		else $error("more than one select in a write record");

	dataout_needs_hit: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout |-> porthit)
		else $error("dataout high without porthit");

endmodule

bind zports_top zports_asserts asserts_i
(
	.zclk,
	.rst_n,
	.cycle,
	.wr_rec,
	.porthit,
	.dataout
);

// File: zports_pkg.sv
/*
 * zports shared definitions
 * port addresses, XT register indices and the pipeline records
 */
package zports_pkg;

	// meaningful widths
	typedef logic [7:0]  zbyte_t; // z80 data byte
	typedef logic [15:0] zaddr_t; // full i/o address
	typedef logic [8:0]  offs_t;  // scroll offset or frame int line

	////////////////////////////////////////
	// port low bytes
	////////////////////////////////////////

	localparam zbyte_t PORT_FE = 8'hFE; // border, keyboard, tape
	localparam zbyte_t PORT_XT = 8'hAF; // extension register file
	localparam zbyte_t PORT_FD = 8'hFD; // 7FFD paging
	localparam zbyte_t PORT_F7 = 8'hF7; // EFF7 config
	localparam zbyte_t PORT_BE = 8'hBE; // config readback

	////////////////////////////////////////
	// #nnAF indices, taken from A15..A8
	////////////////////////////////////////

	localparam zbyte_t XT_VCONF   = 8'h00;
	localparam zbyte_t XT_VPAGE   = 8'h01;
	localparam zbyte_t XT_XOFFSL  = 8'h02;
	localparam zbyte_t XT_XOFFSH  = 8'h03; // bit 0 only
	localparam zbyte_t XT_YOFFSL  = 8'h04;
	localparam zbyte_t XT_YOFFSH  = 8'h05; // bit 0 only
	localparam zbyte_t XT_TSCONF  = 8'h06;
	localparam zbyte_t XT_PALSEL  = 8'h07;
	localparam zbyte_t XT_BORDER  = 8'h0F;
	localparam zbyte_t XT_SYSCONF = 8'h20;
	localparam zbyte_t XT_MEMCONF = 8'h21;
	localparam zbyte_t XT_HSINT   = 8'h22;
	localparam zbyte_t XT_VSINTL  = 8'h23;
	localparam zbyte_t XT_VSINTH  = 8'h24; // bit 0 only
	localparam zbyte_t XT_IM2VECT = 8'h25;

	////////////////////////////////////////
	// pipeline records
	////////////////////////////////////////

	// stage one, one z80 i/o cycle
	typedef struct packed
	{
		logic   wr;   // write strobe, one cycle
		logic   rd;   // read strobe, one cycle
		zaddr_t addr; // captured with the strobe
		zbyte_t data;
	} bus_cycle_t;

	// stage two, decoded write
	typedef struct packed
	{
		logic   fe;    // #FE
		logic   xt;    // #nnAF
		logic   p7ffd; // #7FFD
		logic   eff7;  // #EFF7
		zbyte_t idx;   // high address byte
		zbyte_t data;
	} port_write_t;

endpackage

// File: zports_top.sv
/*
 * zports top level
 * strobe, decode and register stages plus the read mux
 */
`timescale 1ns/1ps

module zports_top
#(
	parameter zports_pkg::zbyte_t HINT_RESET = 8'd2
)
(
	input  logic               zclk,
	input  logic               rst_n,
	input  zports_pkg::zaddr_t addr,
	input  zports_pkg::zbyte_t din,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               dos,
	input  logic               tape_read,
	input  logic [4:0]         keys_in,
	output zports_pkg::zbyte_t dout,
	output logic               porthit,
	output logic               dataout,
	output zports_pkg::zbyte_t border,
	output zports_pkg::zbyte_t vconf,
	output zports_pkg::zbyte_t vpage,
	output zports_pkg::offs_t  x_offs,
	output zports_pkg::offs_t  y_offs,
	output zports_pkg::zbyte_t tsconf,
	output logic [3:0]         palsel,
	output zports_pkg::zbyte_t sysconf,
	output zports_pkg::zbyte_t memconf,
	output zports_pkg::zbyte_t hint_beg,
	output zports_pkg::offs_t  vint_beg,
	output zports_pkg::zbyte_t im2vect,
	output logic               y_offs_wr,
	output logic               p7ffd_wr,
	output zports_pkg::zbyte_t peff7,
	output logic [5:0]         pent1m_page,
	output logic               pent1m_1m_on,
	output logic               pent1m_ram0_0
);
	import zports_pkg::*;

	bus_cycle_t  cycle;
	port_write_t wr_rec;
	zbyte_t      p7ffd;
	zbyte_t      peff7_raw;

	zbus_strobe strobe_i (.zclk, .rst_n, .addr, .din, .iorq_n, .rd_n, .wr_n, .cycle);

	port_decode decode_i (.zclk, .rst_n, .dos, .cycle, .wr_rec);

	xt_regs #(.HINT_RESET(HINT_RESET)) xt_i
	(
		.zclk, .rst_n, .wr_rec,
		.border, .vconf, .tsconf, .sysconf, .memconf, .hint_beg, .im2vect,
		.palsel, .x_offs, .y_offs, .vint_beg, .y_offs_wr
	);

	mem_paging paging_i
	(
		.zclk, .rst_n, .wr_rec,
		.vpage, .p7ffd, .peff7_raw, .peff7,
		.pent1m_page, .pent1m_1m_on, .pent1m_ram0_0, .p7ffd_wr
	);

	// read path is combinational from the bus
	port_readback readback_i
	(
		.addr, .iorq_n, .rd_n, .tape_read, .keys_in,
		.p7ffd, .peff7_raw,
		.dout, .porthit, .dataout
	);

endmodule
